//--- hw/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// Widths
	localparam int REG_ADDR_W = 5;
	localparam int OP3_W      = 6;
	localparam int STEP_W     = 3; // Longest sequence is 7 steps

	localparam logic [REG_ADDR_W-1:0] REG_LINK   = 5'd15; // CALL return address register
	localparam logic [OP3_W-1:0]      OP3_JMPL   = 6'h38;
	localparam logic [OP3_W-1:0]      ALU_OP_ADD = 6'h00; // Add without flag update

	// Format 0 op2 values
	localparam logic [2:0] OP2_SETHI = 3'd4;
	localparam logic [2:0] OP2_BICC  = 3'd2;

	// Format 2 codes with no sequence here
	localparam logic [OP3_W-1:0] OP3_WRTBR   = 6'h33;
	localparam logic [OP3_W-1:0] OP3_SAVE    = 6'h3C;
	localparam logic [OP3_W-1:0] OP3_RESTORE = 6'h3D;

	// Format 3 single loads
	localparam logic [OP3_W-1:0] OP3_LD   = 6'h00;
	localparam logic [OP3_W-1:0] OP3_LDUB = 6'h01;
	localparam logic [OP3_W-1:0] OP3_LDUH = 6'h02;
	localparam logic [OP3_W-1:0] OP3_LDSB = 6'h09;
	localparam logic [OP3_W-1:0] OP3_LDSH = 6'h0A;
	// Format 3 single stores
	localparam logic [OP3_W-1:0] OP3_ST  = 6'h04;
	localparam logic [OP3_W-1:0] OP3_STB = 6'h05;
	localparam logic [OP3_W-1:0] OP3_STH = 6'h06;

	typedef enum logic [1:0] {
		FMT_BRANCH = 2'b00, // SETHI and Bicc
		FMT_CALL   = 2'b01,
		FMT_ARITH  = 2'b10,
		FMT_MEM    = 2'b11
	} fmt_e;

	typedef enum logic [3:0] {
		CLS_SETHI, CLS_BR_TAKEN, CLS_BR_NOT, CLS_BR_ANNUL, CLS_CALL,
		CLS_JMPL, CLS_ALU, CLS_LOAD, CLS_STORE, CLS_ILLEGAL
	} instr_class_e;

	typedef enum logic [1:0] {A_RF = 2'b00, A_PC = 2'b01, A_NPC = 2'b10} alu_a_sel_e;

	typedef enum logic [2:0] {
		B_RF = 3'b000, B_EXT = 3'b001, B_MDR = 3'b010, B_PC = 3'b011,
		B_FOUR = 3'b110 // Constant 4 for nPC + 4
	} alu_b_sel_e;

	typedef enum logic [1:0] {EXT_SIMM13, EXT_DISP22_HI, EXT_DISP22, EXT_DISP30} ext_sel_e;

	typedef enum logic {MDR_ALU, MDR_MEM} mdr_sel_e;

	typedef struct packed {
		logic npc_enable;
		logic pc_enable;
		logic mdr_enable;
		logic mar_enable;
		logic rf_write;
		logic ram_enable;
		logic psr_enable;
		ext_sel_e ext_sel;
		alu_a_sel_e alu_a_sel;
		alu_b_sel_e alu_b_sel;
		mdr_sel_e mdr_sel;
		logic [REG_ADDR_W-1:0] rf_pc; // Write port address
		logic [REG_ADDR_W-1:0] rf_pa;
		logic [REG_ADDR_W-1:0] rf_pb;
		logic [OP3_W-1:0] alu_op;
		logic [OP3_W-1:0] ram_opcode;
	} ctrl_word_t;

	typedef struct packed {
		instr_class_e cls;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic imm; // i bit
		logic [OP3_W-1:0] op3;
	} decoded_t;

	typedef struct packed {
		logic active;             // A step is to be shown
		logic [STEP_W-1:0] step;  // Step number from 1
		logic last;               // Step ends the instruction
	} step_t;

endpackage

`default_nettype wire

//--- hw/cu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cu_decode (
	input  wire logic [31:0] ir,
	input  wire logic        cond,
	output cu_pkg::decoded_t dec
);
	import cu_pkg::*;

	fmt_e fmt;
	logic [2:0] op2;
	logic [OP3_W-1:0] op3;
	logic annul;

	assign fmt   = fmt_e'(ir[31:30]);
	assign op2   = ir[24:22];
	assign op3   = ir[24:19];
	assign annul = ir[29]; // Only meaningful for Bicc

	always_comb begin
		dec     = '0;
		dec.cls = CLS_ILLEGAL;
		dec.rd  = ir[29:25];
		dec.rs1 = ir[18:14];
		dec.rs2 = ir[4:0];
		dec.imm = ir[13];
		dec.op3 = op3;

		case (fmt)
			FMT_BRANCH: begin
				if (op2 == OP2_SETHI) begin
					dec.cls = CLS_SETHI;
				end else if (op2 == OP2_BICC) begin
					// Condition evaluated outside, sampled here with ir
					if (cond)
						dec.cls = CLS_BR_TAKEN;
					else if (annul)
						dec.cls = CLS_BR_ANNUL; // Delay slot skipped
					else
						dec.cls = CLS_BR_NOT;
				end
			end
			FMT_CALL: dec.cls = CLS_CALL;
			FMT_ARITH: begin
				case (op3)
					OP3_JMPL: dec.cls = CLS_JMPL;
					OP3_SAVE, OP3_RESTORE, OP3_WRTBR: dec.cls = CLS_ILLEGAL; // Window and TBR ops
					default: dec.cls = CLS_ALU;
				endcase
			end
			FMT_MEM: begin
				case (op3)
					OP3_LD, OP3_LDUB, OP3_LDUH, OP3_LDSB, OP3_LDSH: dec.cls = CLS_LOAD;
					OP3_ST, OP3_STB, OP3_STH: dec.cls = CLS_STORE;
					default: dec.cls = CLS_ILLEGAL; // Doubles, SWAP and the rest
				endcase
			end
			default: dec.cls = CLS_ILLEGAL;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/cu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Registered state is the step on ctrl now; cur and st give the step for the next cycle
module cu_sequencer (
	input  wire logic             Clk,
	input  wire logic             RESET,
	input  wire logic             ir_strobe,
	input  wire logic             mfc,
	input  wire cu_pkg::decoded_t dec,
	output cu_pkg::decoded_t      cur,
	output cu_pkg::step_t         st
);
	import cu_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_WAIT} exec_state_e;

	exec_state_e state_q, state_d;
	logic [STEP_W-1:0] step_q, step_d;
	decoded_t cur_q, cur_d;
	logic showing_last;
	logic last_d;

	function automatic logic [STEP_W-1:0] seq_len(input instr_class_e cls);
		case (cls)
			CLS_SETHI, CLS_ALU: seq_len = 3'd2;
			CLS_BR_TAKEN, CLS_BR_NOT: seq_len = 3'd3;
			CLS_CALL, CLS_BR_ANNUL: seq_len = 3'd4;
			CLS_JMPL: seq_len = 3'd5;
			CLS_STORE: seq_len = 3'd6;
			CLS_LOAD: seq_len = 3'd7;
			default: seq_len = 3'd1; // Illegal gets one empty word
		endcase
	endfunction

	// Step that waits on memory, zero when there is none
	function automatic logic [STEP_W-1:0] wait_step(input instr_class_e cls);
		case (cls)
			CLS_LOAD: wait_step = 3'd4;
			CLS_STORE: wait_step = 3'd6; // Store ends on its wait
			default: wait_step = 3'd0;
		endcase
	endfunction

	assign showing_last = (state_q == ST_RUN) && (step_q == seq_len(cur_q.cls));

	always_comb begin
		cur_d   = cur_q;
		state_d = state_q;
		step_d  = step_q;
		if (state_q == ST_IDLE || showing_last) begin
			if (ir_strobe) begin // Accept, also in the done cycle
				cur_d   = dec;
				state_d = ST_RUN;
				step_d  = STEP_W'(1);
			end else begin
				state_d = ST_IDLE;
				step_d  = '0;
			end
		end else if (state_q == ST_WAIT) begin
			// Wait word repeats, this repeat is the final one once mfc is seen
			if (mfc)
				state_d = ST_RUN;
		end else begin
			step_d = step_q + STEP_W'(1);
			// mfc low at the edge into the wait step makes it repeat
			if (step_d == wait_step(cur_q.cls) && !mfc)
				state_d = ST_WAIT;
		end
		last_d = (state_d == ST_RUN) && (step_d == seq_len(cur_d.cls));
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			state_q <= ST_IDLE;
			step_q  <= '0;
		end else begin
			state_q <= state_d;
			step_q  <= step_d;
		end
	end

	always_ff @(posedge Clk) begin
		cur_q <= cur_d; // Held instruction
	end

	assign cur       = cur_d;
	assign st.active = (state_d != ST_IDLE);
	assign st.step   = step_d;
	assign st.last   = last_d;

endmodule

`default_nettype wire

//--- hw/cu_control_word.sv
`timescale 1ns/1ps
`default_nettype none

module cu_control_word (
	input  wire logic             Clk,
	input  wire logic             RESET,
	input  wire cu_pkg::decoded_t cur,
	input  wire cu_pkg::step_t    st,
	output cu_pkg::ctrl_word_t    ctrl,
	output logic                  busy,
	output logic                  done,
	output logic                  illegal
);
	import cu_pkg::*;

	ctrl_word_t word_d;
	logic is_illegal;

	// Second ALU operand from rs2 or the sign extended simm13
	function automatic ctrl_word_t add_opb(input ctrl_word_t w_in, input decoded_t d);
		ctrl_word_t w_out;
		w_out = w_in;
		if (d.imm) begin
			w_out.alu_b_sel = B_EXT;
			w_out.ext_sel   = EXT_SIMM13;
		end else begin
			w_out.alu_b_sel = B_RF;
			w_out.rf_pb     = d.rs2;
		end
		return w_out;
	endfunction

	assign is_illegal = st.active && (cur.cls == CLS_ILLEGAL);

	// Fields carry over between steps and enables last one step
	always_comb begin
		word_d        = '0;
		word_d.alu_op = ALU_OP_ADD;
		if (st.active) begin
			case (cur.cls)
				CLS_SETHI: begin
					word_d.rf_pc     = cur.rd;
					word_d.rf_pa     = '0; // r0 plus imm22 << 10
					word_d.alu_b_sel = B_EXT;
					word_d.ext_sel   = EXT_DISP22_HI;
					word_d.rf_write  = (st.step == 3'd2);
				end
				CLS_ALU: begin
					word_d.rf_pc      = cur.rd;
					word_d.rf_pa      = cur.rs1;
					word_d            = add_opb(word_d, cur);
					word_d.alu_op     = cur.op3; // op3 drives the ALU directly
					word_d.rf_write   = (st.step == 3'd2);
					word_d.psr_enable = (st.step == 3'd2) && cur.op3[4]; // cc variants
				end
				CLS_CALL: begin
					word_d.rf_pc = REG_LINK;
					if (st.step <= 3'd2) begin
						word_d.rf_pa     = '0; // r15 = PC
						word_d.alu_b_sel = B_PC;
					end else begin
						word_d.rf_pa     = REG_LINK; // nPC = r15 + 4*disp30
						word_d.alu_b_sel = B_EXT;
						word_d.ext_sel   = EXT_DISP30;
					end
					word_d.pc_enable  = (st.step == 3'd2);
					word_d.rf_write   = (st.step == 3'd2);
					word_d.npc_enable = (st.step == 3'd4);
				end
				CLS_JMPL: begin
					word_d.rf_pc = cur.rd;
					if (st.step <= 3'd3) begin
						word_d.rf_pa     = '0; // Link value is PC
						word_d.alu_b_sel = B_PC;
					end else begin
						word_d.rf_pa = cur.rs1; // Jump target
						word_d       = add_opb(word_d, cur);
					end
					word_d.rf_write   = (st.step == 3'd2);
					word_d.pc_enable  = (st.step == 3'd3); // PC = nPC
					word_d.npc_enable = (st.step == 3'd5);
				end
				CLS_BR_TAKEN, CLS_BR_NOT: begin
					word_d.pc_enable = (st.step == 3'd1); // Delay slot executes
					if (st.step >= 3'd2) begin
						if (cur.cls == CLS_BR_TAKEN) begin
							word_d.alu_a_sel = A_PC; // PC + 4*disp22
							word_d.alu_b_sel = B_EXT;
							word_d.ext_sel   = EXT_DISP22;
						end else begin
							word_d.alu_a_sel = A_NPC;
							word_d.alu_b_sel = B_FOUR;
						end
					end
					word_d.npc_enable = (st.step == 3'd3);
				end
				CLS_BR_ANNUL: begin
					// nPC + 4 twice around PC = nPC skips the slot
					word_d.alu_a_sel  = A_NPC;
					word_d.alu_b_sel  = B_FOUR;
					word_d.npc_enable = (st.step == 3'd2) || (st.step == 3'd4);
					word_d.pc_enable  = (st.step == 3'd3);
				end
				CLS_LOAD: begin
					word_d.rf_pc      = cur.rd;
					word_d.rf_pa      = cur.rs1; // Address rs1 + operand B
					word_d            = add_opb(word_d, cur);
					word_d.ram_opcode = cur.op3; // Size and sign from op3
					if (st.step >= 3'd3)
						word_d.mdr_sel = MDR_MEM;
					if (st.step >= 3'd6) begin
						word_d.rf_pa     = '0; // rd = r0 + MDR
						word_d.alu_b_sel = B_MDR;
						word_d.rf_pb     = '0;
					end
					word_d.mar_enable = (st.step == 3'd2);
					word_d.ram_enable = (st.step == 3'd3);
					word_d.mdr_enable = (st.step == 3'd5); // After the wait step
					word_d.rf_write   = (st.step == 3'd7);
				end
				CLS_STORE: begin
					word_d.rf_pa      = cur.rs1;
					word_d            = add_opb(word_d, cur);
					word_d.ram_opcode = cur.op3;
					if (st.step >= 3'd3) begin
						word_d.rf_pa     = cur.rd; // Store data is rd + r0
						word_d.alu_b_sel = B_RF;
						word_d.rf_pb     = '0;
						word_d.mdr_sel   = MDR_ALU;
					end
					word_d.mar_enable = (st.step == 3'd2);
					word_d.mdr_enable = (st.step == 3'd4);
					word_d.ram_enable = (st.step == 3'd5);
				end
				default: word_d = '0; // Nothing moves
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			ctrl    <= '0;
			busy    <= 1'b0;
			done    <= 1'b0;
			illegal <= 1'b0;
		end else begin
			ctrl    <= word_d;
			busy    <= st.active;
			done    <= st.last;
			illegal <= is_illegal;
		end
	end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  wire logic          Clk,
	input  wire logic          RESET,
	input  wire logic [31:0]   ir,
	input  wire logic          ir_strobe,
	input  wire logic          cond,      // Bicc condition, sampled with ir
	input  wire logic          mfc,       // Memory function complete
	output cu_pkg::ctrl_word_t ctrl,
	output logic               busy,
	output logic               done,
	output logic               illegal
);
	import cu_pkg::*;

	decoded_t dec; // Decode of ir as presented
	decoded_t cur; // Instruction of the next step
	step_t st;

	cu_decode u_decode (
		.ir   (ir),
		.cond (cond),
		.dec  (dec)
	);

	cu_sequencer u_sequencer (
		.Clk       (Clk),
		.RESET     (RESET),
		.ir_strobe (ir_strobe),
		.mfc       (mfc),
		.dec       (dec),
		.cur       (cur),
		.st        (st)
	);

	// Output register stage
	cu_control_word u_control_word (
		.Clk     (Clk),
		.RESET   (RESET),
		.cur     (cur),
		.st      (st),
		.ctrl    (ctrl),
		.busy    (busy),
		.done    (done),
		.illegal (illegal)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic Clk,
	output logic RESET
);
	initial begin
		Clk   = 1'b0;
		RESET = 1'b1;
		repeat (5) @(posedge Clk); // Five reset edges
		RESET <= 1'b0;
	end

	always #4 Clk = ~Clk; // 8 ns period

endmodule

`default_nettype wire

//--- verif/cu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cu_assertions (
	input wire logic               Clk,
	input wire logic               RESET,
	input wire cu_pkg::ctrl_word_t ctrl,
	input wire logic               busy,
	input wire logic               done,
	input wire logic               illegal
);
	import cu_pkg::*;

	logic any_enable;

	assign any_enable = ctrl.npc_enable | ctrl.pc_enable | ctrl.mdr_enable | ctrl.mar_enable
		| ctrl.rf_write | ctrl.ram_enable | ctrl.psr_enable;

	done_in_busy: assert property (@(posedge Clk) disable iff (RESET) done |-> busy)
		else $error("done seen while busy is low");

	illegal_quiet: assert property (@(posedge Clk) disable iff (RESET) illegal |-> !any_enable)
		else $error("enable raised for an illegal instruction");

	// Address load and write back never share a step
	mar_rf_apart: assert property (@(posedge Clk) disable iff (RESET)
		!(ctrl.mar_enable && ctrl.rf_write))
		else $error("mar_enable and rf_write high together");

endmodule

bind control_unit cu_assertions u_cu_assertions (
	.Clk     (Clk),
	.RESET   (RESET),
	.ctrl    (ctrl),
	.busy    (busy),
	.done    (done),
	.illegal (illegal)
);

`default_nettype wire

//--- verif/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;
	import cu_pkg::*;

	localparam int NUM_INSTR   = 400;
	localparam int CYCLE_LIMIT = NUM_INSTR * (7 + 8 + 2); // Longest sequence, waits, gap
	localparam logic [OP3_W-1:0] LOAD_OPS [5] = '{OP3_LD, OP3_LDUB, OP3_LDUH, OP3_LDSB, OP3_LDSH};
	localparam logic [OP3_W-1:0] STORE_OPS [3] = '{OP3_ST, OP3_STB, OP3_STH};

	logic Clk;
	logic RESET;
	logic [31:0] ir;
	logic ir_strobe;
	logic cond;
	logic mfc;
	ctrl_word_t ctrl;
	logic busy;
	logic done;
	logic illegal;

	logic [31:0] lfsr;           // Random source
	ctrl_word_t exp_words[$];    // Expected ctrl per cycle of the current instruction
	logic exp_mfc[$];            // mfc to drive in that cycle
	logic exp_illegal;
	logic [7:0] exp_len;
	logic [7:0] busy_cycles;     // Cycles the DUT showed busy for this instruction
	int pos;
	bit active;
	bit pending;                 // Strobe accepted at the coming edge
	logic [31:0] pend_ir;
	logic pend_cond;
	logic [2:0] pend_delay;
	int issued;
	int completed;
	int cycles;
	int gap;

	tb_clock u_clock (.Clk(Clk), .RESET(RESET));

	control_unit u_control_unit (
		.Clk       (Clk),
		.RESET     (RESET),
		.ir        (ir),
		.ir_strobe (ir_strobe),
		.cond      (cond),
		.mfc       (mfc),
		.ctrl      (ctrl),
		.busy      (busy),
		.done      (done),
		.illegal   (illegal)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1); // Galois form
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "ctrl word differs");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "flag differs");
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1, "cycle count differs");
		end
	endtask

	task automatic check_idle();
		check_ctrl("ctrl", '0, ctrl);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("illegal", 1'b0, illegal);
	endtask

	// Class from op, op2 and op3 as the instruction set defines them
	function automatic instr_class_e classify(input logic [31:0] w, input logic c);
		logic [OP3_W-1:0] op3;
		op3 = w[24:19];
		case (w[31:30])
			2'b00: begin
				if (w[24:22] == OP2_SETHI)
					return CLS_SETHI;
				if (w[24:22] != OP2_BICC)
					return CLS_ILLEGAL;
				if (c)
					return CLS_BR_TAKEN;
				return w[29] ? CLS_BR_ANNUL : CLS_BR_NOT; // Annul bit
			end
			2'b01: return CLS_CALL;
			2'b10: begin
				if (op3 == OP3_JMPL)
					return CLS_JMPL;
				if (op3 inside {OP3_SAVE, OP3_RESTORE, OP3_WRTBR})
					return CLS_ILLEGAL;
				return CLS_ALU;
			end
			default: begin
				if (op3 inside {OP3_LD, OP3_LDUB, OP3_LDUH, OP3_LDSB, OP3_LDSH})
					return CLS_LOAD;
				if (op3 inside {OP3_ST, OP3_STB, OP3_STH})
					return CLS_STORE;
				return CLS_ILLEGAL;
			end
		endcase
	endfunction

	function automatic ctrl_word_t with_operand_b(input ctrl_word_t cw, input logic [31:0] w);
		if (w[13]) begin
			cw.alu_b_sel = B_EXT;
			cw.ext_sel   = EXT_SIMM13;
		end else begin
			cw.alu_b_sel = B_RF;
			cw.rf_pb     = w[4:0];
		end
		return cw;
	endfunction

	// Queue one word, then drop its one-step enables
	task automatic emit(inout ctrl_word_t cw);
		exp_words.push_back(cw);
		exp_mfc.push_back(1'b1);
		cw.npc_enable = 1'b0;
		cw.pc_enable  = 1'b0;
		cw.mdr_enable = 1'b0;
		cw.mar_enable = 1'b0;
		cw.rf_write   = 1'b0;
		cw.ram_enable = 1'b0;
		cw.psr_enable = 1'b0;
	endtask

	task automatic build_trace(input logic [31:0] w, input logic c, input logic [2:0] d);
		ctrl_word_t cw;
		instr_class_e cls;
		int low_from;
		cls = classify(w, c);
		cw = '0;
		low_from = -1;
		exp_words.delete();
		exp_mfc.delete();
		exp_illegal = (cls == CLS_ILLEGAL);
		case (cls)
			CLS_SETHI: begin
				cw.rf_pc = w[29:25];
				cw.alu_b_sel = B_EXT;
				cw.ext_sel = EXT_DISP22_HI;
				emit(cw);
				cw.rf_write = 1'b1;
				emit(cw);
				exp_len = 8'd2;
			end
			CLS_ALU: begin
				cw.rf_pc = w[29:25];
				cw.rf_pa = w[18:14];
				cw = with_operand_b(cw, w);
				cw.alu_op = w[24:19];
				emit(cw);
				cw.rf_write = 1'b1;
				cw.psr_enable = w[23]; // op3 bit 4
				emit(cw);
				exp_len = 8'd2;
			end
			CLS_CALL: begin
				cw.rf_pc = REG_LINK;
				cw.alu_b_sel = B_PC;
				emit(cw);
				cw.pc_enable = 1'b1;
				cw.rf_write = 1'b1;
				emit(cw);
				cw.rf_pa = REG_LINK;
				cw.alu_b_sel = B_EXT;
				cw.ext_sel = EXT_DISP30;
				emit(cw);
				cw.npc_enable = 1'b1;
				emit(cw);
				exp_len = 8'd4;
			end
			CLS_JMPL: begin
				cw.rf_pc = w[29:25];
				cw.alu_b_sel = B_PC;
				emit(cw);
				cw.rf_write = 1'b1;
				emit(cw);
				cw.pc_enable = 1'b1;
				emit(cw);
				cw.rf_pa = w[18:14];
				cw = with_operand_b(cw, w);
				emit(cw);
				cw.npc_enable = 1'b1;
				emit(cw);
				exp_len = 8'd5;
			end
			CLS_BR_TAKEN, CLS_BR_NOT: begin
				cw.pc_enable = 1'b1;
				emit(cw);
				cw.alu_a_sel = (cls == CLS_BR_TAKEN) ? A_PC : A_NPC;
				cw.alu_b_sel = (cls == CLS_BR_TAKEN) ? B_EXT : B_FOUR;
				cw.ext_sel = (cls == CLS_BR_TAKEN) ? EXT_DISP22 : EXT_SIMM13;
				emit(cw);
				cw.npc_enable = 1'b1;
				emit(cw);
				exp_len = 8'd3;
			end
			CLS_BR_ANNUL: begin
				cw.alu_a_sel = A_NPC;
				cw.alu_b_sel = B_FOUR;
				emit(cw);
				cw.npc_enable = 1'b1;
				emit(cw);
				cw.pc_enable = 1'b1;
				emit(cw);
				cw.npc_enable = 1'b1;
				emit(cw);
				exp_len = 8'd4;
			end
			CLS_LOAD: begin
				cw.rf_pc = w[29:25];
				cw.rf_pa = w[18:14];
				cw = with_operand_b(cw, w);
				cw.ram_opcode = w[24:19];
				emit(cw);
				cw.mar_enable = 1'b1;
				emit(cw);
				cw.mdr_sel = MDR_MEM;
				cw.ram_enable = 1'b1;
				emit(cw);
				repeat (int'(d) + 1) emit(cw); // Wait word and its repeats
				cw.mdr_enable = 1'b1;
				emit(cw);
				cw.rf_pa = '0;
				cw.alu_b_sel = B_MDR;
				cw.rf_pb = '0;
				emit(cw);
				cw.rf_write = 1'b1;
				emit(cw);
				low_from = 2; // mfc sampled low from the edge into the wait word
				exp_len = 8'd7 + 8'(d);
			end
			CLS_STORE: begin
				cw.rf_pa = w[18:14];
				cw = with_operand_b(cw, w);
				cw.ram_opcode = w[24:19];
				emit(cw);
				cw.mar_enable = 1'b1;
				emit(cw);
				cw.rf_pa = w[29:25];
				cw.alu_b_sel = B_RF;
				cw.rf_pb = '0;
				cw.mdr_sel = MDR_ALU;
				emit(cw);
				cw.mdr_enable = 1'b1;
				emit(cw);
				cw.ram_enable = 1'b1;
				emit(cw);
				repeat (int'(d) + 1) emit(cw);
				low_from = 4;
				exp_len = 8'd6 + 8'(d);
			end
			default: begin
				emit(cw); // One empty word
				exp_len = 8'd1;
			end
		endcase
		if (low_from >= 0) begin
			for (int i = 0; i < int'(d); i++)
				exp_mfc[low_from + i] = 1'b0;
		end
	endtask

	// Fields biased toward kept encodings, raw words now and then
	task automatic make_instr(output logic [31:0] w, output logic c, output logic [2:0] d);
		logic [31:0] r;
		logic [31:0] kind;
		logic [31:0] pick;
		logic [31:0] bits;
		draw(32, r);
		draw(4, kind);
		draw(3, pick);
		draw(4, bits);
		c = bits[3];
		d = bits[2:0];
		case (kind[3:0])
			4'd0: w = {2'b00, r[29:25], OP2_SETHI, r[21:0]};
			4'd1, 4'd2, 4'd3: w = {2'b00, r[29:25], OP2_BICC, r[21:0]};
			4'd4: w = {2'b01, r[29:0]};
			4'd5: w = {2'b10, r[29:25], OP3_JMPL, r[18:0]};
			4'd6, 4'd7: w = {2'b10, r[29:0]};
			4'd8, 4'd9, 4'd10: w = {2'b11, r[29:25], LOAD_OPS[pick % 5], r[18:0]};
			4'd11, 4'd12, 4'd13: w = {2'b11, r[29:25], STORE_OPS[pick % 3], r[18:0]};
			default: w = r;
		endcase
	endtask

	initial begin
		logic [31:0] new_ir;
		logic new_cond;
		logic [2:0] new_delay;
		logic [31:0] v;
		bit can_accept;
		ir = '0;
		ir_strobe = 1'b0;
		cond = 1'b0;
		mfc = 1'b0;
		lfsr = 32'd11;
		active = 0;
		pending = 0;
		issued = 0;
		completed = 0;
		cycles = 0;
		gap = 0;
		pos = 0;
		busy_cycles = '0;
		@(posedge Clk);
		do begin
			@(negedge Clk);
			check_idle();
		end while (RESET);
		@(posedge Clk);
		while (completed < NUM_INSTR) begin
			if (pending) begin
				build_trace(pend_ir, pend_cond, pend_delay);
				pos = 0;
				active = 1;
				pending = 0;
				busy_cycles = '0;
			end else if (active) begin
				pos++;
				if (pos == exp_words.size())
					active = 0;
			end
			can_accept = !active || (pos == exp_words.size() - 1); // Idle or done cycle
			draw(1, v);
			mfc <= active ? exp_mfc[pos] : v[0];
			if (can_accept && issued < NUM_INSTR && gap == 0) begin
				make_instr(new_ir, new_cond, new_delay);
				ir <= new_ir;
				cond <= new_cond;
				ir_strobe <= 1'b1;
				pend_ir = new_ir;
				pend_cond = new_cond;
				pend_delay = new_delay;
				pending = 1;
				issued++;
				draw(2, v);
				gap = int'(v[1:0]);
			end else begin
				if (can_accept && gap > 0)
					gap--;
				draw(32, v);
				ir <= v; // Noise strobes land only mid-sequence and are ignored
				cond <= v[7];
				ir_strobe <= v[3] && active && !can_accept;
			end
			@(negedge Clk);
			if (active) begin
				check_ctrl("ctrl", exp_words[pos], ctrl);
				check_flag("busy", 1'b1, busy);
				if (busy === 1'b1)
					busy_cycles++;
				if (done === 1'b1)
					check_count("latency", exp_len, busy_cycles); // Busy cycles up to DUT done
				check_flag("done", pos == exp_words.size() - 1, done);
				check_flag("illegal", exp_illegal, illegal);
				if (pos == exp_words.size() - 1)
					completed++;
			end else begin
				check_idle();
			end
			@(posedge Clk);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Run did not finish %0d instructions within %0d cycles", NUM_INSTR,
					CYCLE_LIMIT);
				$display("RESULT: FAIL");
				$fatal(1, "timeout");
			end
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/cu_pkg.sv
hw/cu_decode.sv
hw/cu_sequencer.sv
hw/cu_control_word.sv
hw/control_unit.sv
verif/tb_clock.sv
verif/cu_assertions.sv
verif/tb_control_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_control_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
